/* hdl/ram_pkg.sv */
/*
 * Data RAM shared definitions
 * Geometry of the four-lane byte-addressed RAM and the data word
 * type that is read as bytes or as halfwords
 */

package ram_pkg;

	// Geometry
	localparam int ADDR_W     = 10;                   // Byte address width
	localparam int LANES      = 4;                    // Byte lanes per word
	localparam int BYTE_W     = 8;                    // Lane width
	localparam int WORD_W     = 32;                   // Data word width
	localparam int LANE_SEL_W = 2;                    // Byte offset inside a word
	localparam int ROW_W      = ADDR_W - LANE_SEL_W;  // Row index width
	localparam int ROWS       = 1 << ROW_W;           // Rows in each lane

	// One lane byte
	typedef logic [BYTE_W-1:0] byte_t;

	// Full byte address
	typedef logic [ADDR_W-1:0] addr_t;

	// Row index shared by all lanes
	typedef logic [ROW_W-1:0] row_t;

	/*
	 * Data word with two views of the same 32 bits.
	 * bytes[0] is lane 0, the lowest byte.
	 * halves[h][b] is byte b of half h, so halves[0] is bits 15..0.
	 */
	typedef union packed
	{
		byte_t [LANES-1:0] bytes;   // Word view
		byte_t [1:0][1:0]  halves;  // Halfword view
	} data_word_u;

endpackage

/* hdl/lane_write_decode.sv */
/*
 * Lane write decoder
 * Resolves chip select, the word/halfword/byte write strobes and the
 * low address bits into one write enable and one data byte per lane
 */

`timescale 1ns/1ps

module lane_write_decode
	import ram_pkg::*;
(
	input  logic                  cs,
	input  logic                  write_w,
	input  logic                  write_h,
	input  logic                  write_b,
	input  logic [LANE_SEL_W-1:0] lane_sel,
	input  data_word_u            in,
	output logic [LANES-1:0]      lane_we,
	output byte_t                 lane_din [LANES]
);

	logic do_word;   // Word write this cycle
	logic do_half;   // Halfword write, any offset
	logic do_byte;   // Byte write
	logic half_ok;   // Halfword offset is 00 or 10

	// Strobe priority: word over halfword over byte
	assign do_word = cs & write_w;
	assign do_half = cs & write_h & ~write_w;
	assign do_byte = cs & write_b & ~write_w & ~write_h;

	// Only even halfword offsets are aligned
	assign half_ok = ~lane_sel[0];

	always_comb
	begin
		// Disabled lanes see zero data
		lane_we = '0;
		for (int i = 0; i < LANES; i++)
		begin
			lane_din[i] = '0;
		end

		if (do_word)
		begin
			lane_we = '1;
			for (int i = 0; i < LANES; i++)
			begin
				lane_din[i] = in.bytes[i];  // Each lane keeps its own byte
			end
		end
		else if (do_half)
		begin
			// Lower half of in goes to whichever pair is addressed
			if (half_ok)
			begin
				case (lane_sel[1])
					1'b0:
					begin
						lane_we[0]  = 1'b1;
						lane_we[1]  = 1'b1;
						lane_din[0] = in.halves[0][0];
						lane_din[1] = in.halves[0][1];
					end
					1'b1:
					begin
						lane_we[2]  = 1'b1;
						lane_we[3]  = 1'b1;
						lane_din[2] = in.halves[0][0];
						lane_din[3] = in.halves[0][1];
					end
				endcase
			end
			// Misaligned halfword falls through with nothing enabled
		end
		else if (do_byte)
		begin
			// Byte data always comes from bits 7..0
			case (lane_sel)
				2'd0:
				begin
					lane_we[0]  = 1'b1;
					lane_din[0] = in.bytes[0];
				end
				2'd1:
				begin
					lane_we[1]  = 1'b1;
					lane_din[1] = in.bytes[0];
				end
				2'd2:
				begin
					lane_we[2]  = 1'b1;
					lane_din[2] = in.bytes[0];
				end
				2'd3:
				begin
					lane_we[3]  = 1'b1;
					lane_din[3] = in.bytes[0];
				end
			endcase
		end
	end

endmodule

/* hdl/byte_lane_mem.sv */
/*
 * Byte lane memory bank
 * ROWS bytes with a single write enable and a registered,
 * read-first output
 */

`timescale 1ns/1ps

module byte_lane_mem
	import ram_pkg::*;
(
	input  logic  clk,
	input  row_t  row,
	input  logic  we,
	input  byte_t din,
	output byte_t dout
);

	byte_t mem [ROWS];  // Storage, maps to block RAM

	// Contents start at zero
	initial
	begin
		for (int r = 0; r < ROWS; r++)
		begin
			mem[r] = '0;
		end
	end

	// Read register samples the old row before the write lands
	always @(posedge clk)
	begin
		dout <= mem[row];      // Read-first
		if (we)
		begin
			mem[row] <= din;   // Masked by the decoder
		end
	end

endmodule

/* hdl/read_gather.sv */
/*
 * Read data gatherer
 * Joins the four lane bytes into the output word, holds it at zero
 * unless the previous cycle was selected, and drives data_rdy
 */

`timescale 1ns/1ps

module read_gather
	import ram_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       cs,
	input  byte_t      lane_dout [LANES],
	output data_word_u out,
	output logic       data_rdy
);

	data_word_u joined;  // Lane bytes as one word

	// Delayed select, also the ready strobe
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			data_rdy <= 1'b0;
		end
		else
		begin
			data_rdy <= cs;
		end
	end

	// Lane 0 is the lowest byte
	always_comb
	begin
		for (int i = 0; i < LANES; i++)
		begin
			joined.bytes[i] = lane_dout[i];
		end
	end

	// Bank outputs are stale after an unselected edge
	always_comb
	begin
		out = {WORD_W{1'b0}};
		if (data_rdy)
		begin
			out = joined;
		end
	end

endmodule

/* hdl/ram.sv */
/*
 * 1 KiB single-port data RAM
 * Four byte lanes of 256 rows with word, halfword and byte writes
 * and a one-cycle synchronous read
 */

`timescale 1ns/1ps

module ram
	import ram_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  addr_t      addr,
	input  logic       cs,
	input  data_word_u in,
	input  logic       write_w,
	input  logic       write_h,
	input  logic       write_b,
	output data_word_u out,
	output logic       data_rdy
);

	row_t                  row;                // Word row, common to all lanes
	logic [LANE_SEL_W-1:0] lane_sel;           // Byte offset in the word
	logic [LANES-1:0]      lane_we;            // Per-lane write enable
	byte_t                 lane_din [LANES];   // Per-lane write byte
	byte_t                 lane_dout [LANES];  // Per-lane read byte

	// Upper bits pick the row, low bits the lane
	assign row      = addr[ADDR_W-1:LANE_SEL_W];
	assign lane_sel = addr[LANE_SEL_W-1:0];

	lane_write_decode u_decode
	(
		.cs       (cs),
		.write_w  (write_w),
		.write_h  (write_h),
		.write_b  (write_b),
		.lane_sel (lane_sel),
		.in       (in),
		.lane_we  (lane_we),
		.lane_din (lane_din)
	);

	// One bank per byte lane
	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		byte_lane_mem u_mem
		(
			.clk  (clk),
			.row  (row),
			.we   (lane_we[i]),
			.din  (lane_din[i]),
			.dout (lane_dout[i])
		);
	end

	read_gather u_gather
	(
		.clk       (clk),
		.rst       (rst),
		.cs        (cs),
		.lane_dout (lane_dout),
		.out       (out),
		.data_rdy  (data_rdy)
	);

endmodule

/* test/ram_tb.sv */
/*
 * Data RAM testbench
 * Directed tests against a word-level model of the RAM, with every
 * access checked one cycle after it is issued
 */

`timescale 1ns/1ps

module ram_tb
	import ram_pkg::*;
();

	localparam int CLK_PERIOD  = 100;                            // ns
	localparam int TEST_CYCLES = 2000;                           // Rough length of all tests
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;   // Twice the expected run

	logic       clk;
	logic       rst;
	addr_t      addr;
	logic       cs;
	data_word_u in;
	logic       write_w;
	logic       write_h;
	logic       write_b;
	data_word_u out;
	logic       data_rdy;

	data_word_u model [ROWS];  // Expected contents, one word per row

	int error_count;
	int errors_at_start;   // Error count when the current test began
	int tests_passed;
	int tests_failed;

	always #(CLK_PERIOD / 2) clk = ~clk;

	ram UUT
	(
		.clk      (clk),
		.rst      (rst),
		.addr     (addr),
		.cs       (cs),
		.in       (in),
		.write_w  (write_w),
		.write_h  (write_h),
		.write_b  (write_b),
		.out      (out),
		.data_rdy (data_rdy)
	);

	task automatic check_word(input string name, input data_word_u expected,
		input data_word_u actual);
		if (actual !== expected)
		begin
			$display("Error: %s out expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("Error: %s data_rdy expected %b actual %b", name, expected, actual);
			error_count++;
		end
	endtask

	// Word, then halfword, then byte; misaligned halfwords are dropped
	function automatic void apply_write(input addr_t a, input logic sel, input data_word_u d,
		input logic ww, input logic wh, input logic wb);
		row_t       r;
		logic [1:0] off;
		data_word_u w;
		r   = a[ADDR_W-1:LANE_SEL_W];
		off = a[LANE_SEL_W-1:0];
		w   = model[r];
		if (sel && ww)
		begin
			w = d;
		end
		else if (sel && wh)
		begin
			if (off == 2'd0)
			begin
				w.halves[0] = d.halves[0];
			end
			else if (off == 2'd2)
			begin
				w.halves[1] = d.halves[0];  // Upper half takes the low half of in
			end
		end
		else if (sel && wb)
		begin
			w.bytes[off] = d.bytes[0];
		end
		model[r] = w;
	endfunction

	// One clock of stimulus, checked at the next edge
	task automatic drive_cycle(input string name, input addr_t a, input logic sel,
		input data_word_u d, input logic ww, input logic wh, input logic wb);
		data_word_u expected;
		logic       expected_rdy;
		addr    = a;
		cs      = sel;
		in      = d;
		write_w = ww;
		write_h = wh;
		write_b = wb;
		expected_rdy = sel;
		expected     = '0;
		if (sel)
		begin
			expected = model[a[ADDR_W-1:LANE_SEL_W]];  // Old content, read-first
		end
		apply_write(a, sel, d, ww, wh, wb);
		@(posedge clk);
		#1;
		check_bit(name, expected_rdy, data_rdy);
		check_word(name, expected, out);
	endtask

	task automatic read_word(input string name, input addr_t a);
		drive_cycle(name, a, 1'b1, '0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic write_word(input string name, input addr_t a, input data_word_u d);
		drive_cycle(name, a, 1'b1, d, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = error_count - errors_at_start;
		if (errs == 0)
		begin
			$display("%s: passed", name);
			tests_passed++;
		end
		else
		begin
			$display("%s: failed with %0d errors", name, errs);
			tests_failed++;
		end
	endtask

	task automatic test_reset_state();
		errors_at_start = error_count;
		rst = 1'b1;
		repeat (10)
		begin
			@(posedge clk);
			#1;
			check_bit("reset_state", 1'b0, data_rdy);
			check_word("reset_state", '0, out);
		end
		rst = 1'b0;
		drive_cycle("reset_state", 10'd0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
		read_word("reset_state", 10'd20);                // Unwritten row
		end_test("reset_state");
	endtask

	task automatic test_word_rw();
		errors_at_start = error_count;
		write_word("word_rw", 10'd0, 32'h0123_4567);
		write_word("word_rw", 10'd4, 32'h89ab_cdef);
		write_word("word_rw", 10'd28, 32'hdead_beef);
		write_word("word_rw", 10'd513, 32'h5a5a_a5a5);   // Offset ignored for words
		write_word("word_rw", 10'd1020, 32'hfeed_f00d);  // Last row
		read_word("word_rw", 10'd0);                     // Back-to-back reads
		read_word("word_rw", 10'd4);
		read_word("word_rw", 10'd28);
		read_word("word_rw", 10'd512);
		read_word("word_rw", 10'd1020);
		end_test("word_rw");
	endtask

	task automatic test_half_writes();
		errors_at_start = error_count;
		write_word("halfword_writes", 10'd40, 32'h1122_3344);
		drive_cycle("halfword_writes", 10'd40, 1'b1, 32'hffff_bbcc, 1'b0, 1'b1, 1'b0);
		drive_cycle("halfword_writes", 10'd42, 1'b1, 32'heeee_7788, 1'b0, 1'b1, 1'b0);
		read_word("halfword_writes", 10'd40);
		write_word("halfword_writes", 10'd44, 32'h5566_7788);
		drive_cycle("halfword_writes", 10'd45, 1'b1, 32'h0000_1234, 1'b0, 1'b1, 1'b0);
		drive_cycle("halfword_writes", 10'd47, 1'b1, 32'h0000_9876, 1'b0, 1'b1, 1'b0);
		read_word("halfword_writes", 10'd44);            // Misaligned writes dropped
		end_test("halfword_writes");
	endtask

	task automatic test_byte_priority();
		errors_at_start = error_count;
		drive_cycle("byte_priority", 10'd80, 1'b1, 32'hffff_ff12, 1'b0, 1'b0, 1'b1);
		drive_cycle("byte_priority", 10'd81, 1'b1, 32'hffff_ff34, 1'b0, 1'b0, 1'b1);
		drive_cycle("byte_priority", 10'd82, 1'b1, 32'hffff_ff56, 1'b0, 1'b0, 1'b1);
		drive_cycle("byte_priority", 10'd83, 1'b1, 32'hffff_ff78, 1'b0, 1'b0, 1'b1);
		read_word("byte_priority", 10'd80);
		drive_cycle("byte_priority", 10'd85, 1'b1, 32'hcafe_0001, 1'b1, 1'b0, 1'b1);
		read_word("byte_priority", 10'd84);              // Word beat byte
		drive_cycle("byte_priority", 10'd88, 1'b1, 32'hbead_2468, 1'b1, 1'b1, 1'b0);
		read_word("byte_priority", 10'd88);              // Word beat halfword
		// Row already holds data, so the bank output is nonzero here
		drive_cycle("byte_priority", 10'd88, 1'b0, 32'h1111_1111, 1'b1, 1'b1, 1'b1);
		read_word("byte_priority", 10'd88);              // Unselected write ignored
		end_test("byte_priority");
	endtask

	task automatic test_read_first();
		errors_at_start = error_count;
		write_word("read_first", 10'd120, 32'haaaa_5555);
		write_word("read_first", 10'd120, 32'h1234_abcd);  // Returns aaaa_5555
		read_word("read_first", 10'd120);
		drive_cycle("read_first", 10'd122, 1'b1, 32'h0000_00ee, 1'b0, 1'b0, 1'b1);
		read_word("read_first", 10'd120);
		end_test("read_first");
	endtask

	task automatic test_random_traffic();
		int unsigned r;
		data_word_u  d;
		addr_t       a;
		errors_at_start = error_count;
		for (int n = 0; n < 300; n++)
		begin
			r = $urandom;
			d = $urandom;
			a = {2'b00, r[7:0]};                         // First 64 rows, frequent reuse
			drive_cycle("random_traffic", a, r[8] | r[9], d,
				r[10] & r[11], r[12] & r[13], r[14]);
		end
		drive_cycle("random_traffic", 10'd0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
		end_test("random_traffic");
	endtask

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within the watchdog limit");
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		clk     = 1'b0;
		rst     = 1'b1;
		addr    = '0;
		cs      = 1'b0;
		in      = '0;
		write_w = 1'b0;
		write_h = 1'b0;
		write_b = 1'b0;
		error_count     = 0;
		errors_at_start = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		for (int r = 0; r < ROWS; r++)
		begin
			model[r] = '0;                               // RAM starts cleared
		end
		void'($urandom(32'ha5f1));

		test_reset_state();
		test_word_rw();
		test_half_writes();
		test_byte_priority();
		test_read_first();
		test_random_traffic();

		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
hdl/ram_pkg.sv
hdl/lane_write_decode.sv
hdl/byte_lane_mem.sv
hdl/read_gather.sv
hdl/ram.sv
test/ram_tb.sv

/* run.sh */
#!/bin/sh
# Build the data RAM testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
	-f project.f \
	--top-module ram_tb \
	-o ram_sim

./obj_dir/ram_sim > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log
then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
